/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rot_nn
FILELIST  ?= rot_nn.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* rot_nn.f */
verilog/rot_pkg.sv
verilog/rot_ifs.sv
verilog/rot_apb_regs.sv
verilog/rot_sequencer.sv
verilog/rot_neuron.sv
verilog/rot_collector.sv
verilog/rot_nn.sv
verif/tb_rot_nn.sv

/* verif/tb_rot_nn.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rot_nn import rot_pkg::*; ();

  localparam int clk_period   = 4;
  localparam int num_runs     = 10;  // runs that load a full weight set
  localparam int run_accesses = num_neurons * (num_inputs + num_neurons + 2) + 8;
  localparam int watchdog_ns  = num_runs * (3 * run_accesses + 200) * clk_period;
  localparam int done_timeout = 200;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        done;
  logic [7:0]  angle;

  logic [31:0] lfsr = 32'h42d1635a;
  int          w0 [num_neurons][num_inputs];
  int          b0 [num_neurons];
  int          w1 [num_neurons][num_neurons];
  int          b1 [num_neurons];
  int          px [num_inputs];
  bit          saw_low;   // model hit the clamp at 0
  bit          saw_high;  // and at 255

  rot_nn i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .done    (done),
    .angle   (angle)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string test, input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("[ERROR] %s: %s expected %0d, actual %0d", test, what, exp, act);
      stop_with_failure();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);  // access phase, outputs settled
    rdata = prdata;
    err   = pslverr;
    check_eq("apb", "pready", 1, int'(pready));
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input string test, input logic [11:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    check_eq(test, $sformatf("pslverr on write 0x%03h", addr), int'(exp_err), int'(err));
  endtask

  task automatic apb_read(input string test, input logic [11:0] addr, output logic [31:0] data,
                          input logic exp_err);
    logic err;
    apb_access(1'b0, addr, 32'h0, data, err);
    check_eq(test, $sformatf("pslverr on read 0x%03h", addr), int'(exp_err), int'(err));
  endtask

  function automatic logic [11:0] weight_addr(input int layer, input int nrn, input int idx);
    return 12'h800 | 12'(layer << 10) | 12'(nrn << 7) | 12'(idx << 2);
  endfunction

  task automatic zero_config();
    for (int n = 0; n < num_neurons; n++) begin
      for (int i = 0; i < num_inputs; i++) w0[n][i] = 0;
      for (int j = 0; j < num_neurons; j++) w1[n][j] = 0;
      b0[n] = 0;
      b1[n] = 0;
    end
    for (int i = 0; i < num_inputs; i++) px[i] = 0;
  endtask

  task automatic randomize_config();
    logic [31:0] r;
    for (int n = 0; n < num_neurons; n++) begin
      for (int i = 0; i < num_inputs; i++) begin
        r = rand_bits(8);
        w0[n][i] = int'($signed(r[7:0]));
      end
      for (int j = 0; j < num_neurons; j++) begin
        r = rand_bits(8);
        w1[n][j] = int'($signed(r[7:0]));
      end
      r = rand_bits(16);
      b0[n] = int'($signed(r[15:0]));
      r = rand_bits(16);
      b1[n] = int'($signed(r[15:0]));
    end
    for (int i = 0; i < num_inputs; i++) begin
      r = rand_bits(8);
      px[i] = int'(r[7:0]);
    end
  endtask

  task automatic load_config(input string test);
    for (int n = 0; n < num_neurons; n++) begin
      for (int i = 0; i < num_inputs; i++) apb_write(test, weight_addr(0, n, i), 32'(w0[n][i]), 0);
      apb_write(test, weight_addr(0, n, num_inputs), 32'(b0[n]), 1'b0);
      for (int j = 0; j < num_neurons; j++) apb_write(test, weight_addr(1, n, j), 32'(w1[n][j]), 0);
      apb_write(test, weight_addr(1, n, num_neurons), 32'(b1[n]), 1'b0);
    end
    for (int k = 0; k < num_inputs / 4; k++) begin
      apb_write(test, addr_input + 12'(4 * k), {8'(px[4*k+3]), 8'(px[4*k+2]),
                                               8'(px[4*k+1]), 8'(px[4*k])}, 1'b0);
    end
  endtask

  // bias + sum of w*x, layer 0 shifted and clamped, first maximum wins
  function automatic int model_bin();
    int hid [num_neurons];
    int acc;
    int best;
    int best_val;
    best     = 0;
    best_val = 0;
    for (int n = 0; n < num_neurons; n++) begin
      acc = b0[n];
      for (int i = 0; i < num_inputs; i++) acc += w0[n][i] * px[i];
      acc = acc >>> act_shift;
      if (acc < 0) begin
        acc     = 0;
        saw_low = 1'b1;
      end else if (acc > 255) begin
        acc      = 255;
        saw_high = 1'b1;
      end
      hid[n] = acc;
    end
    for (int n = 0; n < num_neurons; n++) begin
      acc = b1[n];
      for (int j = 0; j < num_neurons; j++) acc += w1[n][j] * hid[j];
      if (n == 0 || acc > best_val) begin
        best     = n;
        best_val = acc;
      end
    end
    return best;
  endfunction

  task automatic wait_done(input string test);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!done && cycles < done_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("%s: done never rose within %0d cycles of start", test, done_timeout);
      stop_with_failure();
    end
    @(negedge clk);
    check_eq(test, "done one cycle later", 0, int'(done));
  endtask

  task automatic check_result(input string test, input int exp);
    logic [31:0] rd;
    apb_read(test, addr_result, rd, 1'b0);
    check_eq(test, "RESULT", exp, int'(rd));
    check_eq(test, "angle", 1 << exp, int'(angle));
    apb_read(test, addr_status, rd, 1'b0);
    check_eq(test, "STATUS", 2, int'(rd));  // done flag, not busy
  endtask

  task automatic run_and_check(input string test, input int exp);
    apb_write(test, addr_ctrl, 32'h1, 1'b0);
    wait_done(test);
    check_result(test, exp);
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    check_eq("reset", "done", 0, int'(done));
    check_eq("reset", "angle", 1, int'(angle));
    apb_read("reset", addr_status, rd, 1'b0);
    check_eq("reset", "STATUS", 0, int'(rd));
    apb_read("reset", addr_result, rd, 1'b0);
    check_eq("reset", "RESULT", 0, int'(rd));
  endtask

  task automatic test_single_bias();
    zero_config();
    b1[5] = 32767;
    load_config("single_bias");
    run_and_check("single_bias", 5);
  endtask

  task automatic test_random();
    for (int run = 0; run < 6; run++) begin
      randomize_config();
      load_config("random");
      run_and_check($sformatf("random run %0d", run), model_bin());
    end
  endtask

  task automatic test_tie();
    zero_config();
    for (int n = 0; n < num_neurons; n++) b1[n] = 100;
    b1[2] = 900;
    b1[6] = 900;
    load_config("tie");
    run_and_check("tie 2 and 6", 2);
    for (int n = 0; n < num_neurons; n++) b1[n] = -50;
    load_config("tie");
    run_and_check("tie all", 0);
  endtask

  task automatic test_busy_lockout();
    logic [31:0] rd;
    int          exp;
    randomize_config();
    load_config("busy");
    exp = model_bin();
    apb_write("busy", addr_ctrl, 32'h1, 1'b0);
    apb_read("busy", addr_status, rd, 1'b0);
    check_eq("busy", "STATUS", 1, int'(rd));  // busy, old done flag gone
    apb_write("busy", weight_addr(1, 3, 0), 32'h7f, 1'b1);
    apb_write("busy", addr_input, 32'hffff_ffff, 1'b1);
    apb_write("busy", addr_ctrl, 32'h1, 1'b1);  // second start
    wait_done("busy");
    check_result("busy", exp);
    apb_read("busy", addr_input, rd, 1'b0);
    check_eq("busy", "INPUT word 0",
             int'({8'(px[3]), 8'(px[2]), 8'(px[1]), 8'(px[0])}), int'(rd));
  endtask

  task automatic test_bad_access();
    logic [31:0] rd;
    apb_read("bad_access", weight_addr(0, 0, 0), rd, 1'b1);
    apb_read("bad_access", weight_addr(1, 7, 8), rd, 1'b1);
    apb_read("bad_access", 12'h020, rd, 1'b1);
    apb_write("bad_access", 12'h00c, 32'h1, 1'b1);
    apb_write("bad_access", weight_addr(0, 2, 20), 32'h1, 1'b1);  // past the bias slot
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run hung", watchdog_ns);
    stop_with_failure();
  end

  initial begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_reset();
    test_single_bias();
    test_random();
    test_tie();
    test_busy_lockout();
    test_bad_access();
    if (saw_low && saw_high) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("random runs never reached both clamp limits of layer 0");
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

/* verilog/rot_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module rot_apb_regs import rot_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  logic [11:0]  paddr,
  input  logic [31:0]  pwdata,
  output logic [31:0]  prdata,
  output logic         pready,
  output logic         pslverr,
  rot_weight_if.master wport,
  output logic         start_pulse,
  input  logic         busy,
  input  logic         done_pulse,
  input  nidx_t        result_idx,
  output pixel_t       pixels [num_inputs]
);

  logic       access;
  logic       wr_ok;
  logic       err;
  logic       in_wreg;
  logic [4:0] w_idx;
  logic       w_is_bias;
  logic       hit_ctrl;
  logic       hit_status;
  logic       hit_result;
  logic       hit_input;
  logic       hit_weight;
  logic [3:0] in_base;
  logic       done_flag;

  assign access  = psel & penable;
  assign in_wreg = paddr[addr_wreg_bit];
  assign w_idx   = paddr[6:2];
  assign in_base = {paddr[3:2], 2'b00};

  assign hit_ctrl   = (paddr == addr_ctrl);
  assign hit_status = (paddr == addr_status);
  assign hit_result = (paddr == addr_result);
  assign hit_input  = (paddr[11:4] == addr_input[11:4]) && (paddr[1:0] == 2'b00);

  // layer in bit 10, neuron in 9:7, index in 6:2
  assign w_is_bias  = paddr[10] ? (w_idx == 5'(bias_idx1)) : (w_idx == 5'(bias_idx0));
  assign hit_weight = in_wreg && (paddr[1:0] == 2'b00) &&
                      (paddr[10] ? (w_idx <= 5'(bias_idx1)) : (w_idx <= 5'(bias_idx0)));

  always_comb begin
    if (pwrite) begin
      // every writable register is locked while a run is going
      err = !(hit_ctrl || hit_input || hit_weight) || busy;
    end else begin
      err = !(hit_ctrl || hit_status || hit_result || hit_input);
    end
  end

  assign pready  = 1'b1;
  assign pslverr = access & err;
  assign wr_ok   = access & pwrite & ~err;

  assign start_pulse = wr_ok & hit_ctrl & pwdata[0];

  assign wport.wr_en      = wr_ok & hit_weight;
  assign wport.layer      = paddr[10];
  assign wport.neuron_sel = paddr[9:7];
  assign wport.widx       = paddr[5:2];
  assign wport.is_bias    = w_is_bias;
  assign wport.wdata      = pwdata[15:0];

  always_ff @(posedge clk) begin
    if (wr_ok && hit_input) begin
      for (int k = 0; k < 4; k++) begin
        pixels[in_base + 4'(k)] <= pwdata[8*k +: 8];  // lowest byte first
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_flag <= 1'b0;
    end else if (start_pulse) begin
      done_flag <= 1'b0;
    end else if (done_pulse) begin
      done_flag <= 1'b1;
    end
  end

  always_comb begin
    prdata = '0;
    if (access && !pwrite && !err) begin
      if (hit_status) begin
        prdata = {30'b0, done_flag, busy};
      end else if (hit_result) begin
        prdata = {29'b0, result_idx};
      end else if (hit_input) begin
        prdata = {pixels[in_base + 4'd3], pixels[in_base + 4'd2],
                  pixels[in_base + 4'd1], pixels[in_base]};
      end
    end
  end

  a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel);

endmodule

`default_nettype wire

/* verilog/rot_collector.sv */
`timescale 1ns/1ns
`default_nettype none

module rot_collector import rot_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   result_valid,
  input  acc_t   results [num_neurons],
  input  logic   layer,
  input  logic   argmax_go,
  output pixel_t hidden [num_neurons],
  output logic   layer_done,
  output logic   argmax_done,
  output nidx_t  result_idx
);

  acc_t  outs [num_neurons];
  acc_t  best_val;
  nidx_t best_idx;
  nidx_t scan_idx;
  logic  scanning;
  logic  take;

  // strict compare so a tie keeps the earlier bin
  assign take = outs[scan_idx] > best_val;

  always_ff @(posedge clk) begin
    if (result_valid) begin
      for (int i = 0; i < num_neurons; i++) begin
        if (layer) begin
          outs[i] <= results[i];
        end else begin
          hidden[i] <= results[i][7:0];  // already clamped
        end
      end
    end
    if (argmax_go) begin
      best_val <= outs[0];
    end else if (scanning && take) begin
      best_val <= outs[scan_idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      layer_done  <= 1'b0;
      argmax_done <= 1'b0;
      scanning    <= 1'b0;
      scan_idx    <= '0;
      best_idx    <= '0;
      result_idx  <= '0;
    end else begin
      layer_done  <= result_valid;
      argmax_done <= 1'b0;
      if (argmax_go) begin
        scanning <= 1'b1;
        scan_idx <= '0;
        best_idx <= '0;
      end else if (scanning) begin
        scan_idx <= scan_idx + 3'd1;
        if (take) begin
          best_idx <= scan_idx;
        end
        if (scan_idx == nidx_t'(num_neurons - 1)) begin
          scanning    <= 1'b0;
          argmax_done <= 1'b1;
          result_idx  <= take ? scan_idx : best_idx;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rot_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

// weight and bias load path, one writer, all neurons listen
interface rot_weight_if import rot_pkg::*; ();
  logic  wr_en;
  logic  layer;
  nidx_t neuron_sel;
  widx_t widx;
  logic  is_bias;
  bias_t wdata;   // weights use the low byte

  modport master (
    output wr_en, layer, neuron_sel, widx, is_bias, wdata
  );

  modport slave (
    input wr_en, layer, neuron_sel, widx, is_bias, wdata
  );
endinterface

// one input value per beat to every neuron
interface rot_bcast_if import rot_pkg::*; ();
  logic   valid;
  logic   first;
  logic   last;
  logic   layer;
  widx_t  widx;
  pixel_t x;

  modport master (
    output valid, first, last, layer, widx, x
  );

  modport slave (
    input valid, first, last, layer, widx, x
  );
endinterface

`default_nettype wire

/* verilog/rot_neuron.sv */
`timescale 1ns/1ns
`default_nettype none

module rot_neuron import rot_pkg::*; #(
  parameter int neuron_id = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  rot_weight_if.slave wport,
  rot_bcast_if.slave  bport,
  output logic        result_valid,
  output acc_t        result
);

  weight_t    wmem [num_weights];  // layer 0 at 0..15, layer 1 at 16..23
  bias_t      bmem [2];
  acc_t       acc;
  acc_t       prod;
  acc_t       shifted;
  logic [4:0] wr_idx;
  logic [4:0] rd_idx;
  logic       res_layer;

  assign wr_idx = wport.layer ? {2'b10, wport.widx[2:0]} : {1'b0, wport.widx};
  assign rd_idx = bport.layer ? {2'b10, bport.widx[2:0]} : {1'b0, bport.widx};

  always_ff @(posedge clk) begin
    if (wport.wr_en && (wport.neuron_sel == nidx_t'(neuron_id))) begin
      if (wport.is_bias) begin
        bmem[wport.layer] <= wport.wdata;
      end else begin
        wmem[wr_idx] <= wport.wdata[7:0];
      end
    end
  end

  // signed weight times unsigned x
  assign prod = acc_t'(wmem[rd_idx]) * acc_t'(bport.x);

  always_ff @(posedge clk) begin
    if (bport.valid) begin
      acc <= bport.first ? acc_t'(bmem[bport.layer]) + prod : acc + prod;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      res_layer    <= 1'b0;
    end else begin
      result_valid <= bport.valid & bport.last;
      if (bport.valid && bport.last) begin
        res_layer <= bport.layer;
      end
    end
  end

  assign shifted = acc >>> act_shift;

  always_comb begin
    if (res_layer) begin
      result = acc;  // output layer stays raw
    end else if (shifted < 0) begin
      result = '0;
    end else if (shifted > 24'sd255) begin
      result = 24'sd255;
    end else begin
      result = shifted;
    end
  end

  a_no_load_during_run: assert property (@(posedge clk) disable iff (!rst_n)
    !(bport.valid && wport.wr_en));

endmodule

`default_nettype wire

/* verilog/rot_nn.sv */
`timescale 1ns/1ns
`default_nettype none

module rot_nn import rot_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        done,
  output logic [7:0]  angle
);

  rot_weight_if w_if ();
  rot_bcast_if  b_if ();

  pixel_t                 pixels  [num_inputs];
  pixel_t                 hidden  [num_neurons];
  acc_t                   results [num_neurons];
  logic [num_neurons-1:0] nrn_valid;
  logic                   start_pulse;
  logic                   busy;
  logic                   done_pulse;
  logic                   layer_done;
  logic                   argmax_go;
  logic                   argmax_done;
  nidx_t                  result_idx;

  rot_apb_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .wport       (w_if.master),
    .start_pulse (start_pulse),
    .busy        (busy),
    .done_pulse  (done_pulse),
    .result_idx  (result_idx),
    .pixels      (pixels)
  );

  rot_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_pulse (start_pulse),
    .pixels      (pixels),
    .hidden      (hidden),
    .bport       (b_if.master),
    .busy        (busy),
    .layer_done  (layer_done),
    .argmax_done (argmax_done),
    .argmax_go   (argmax_go),
    .done_pulse  (done_pulse)
  );

  // same neuron hardware serves both layers
  for (genvar i = 0; i < num_neurons; i++) begin : g_neuron
    rot_neuron #(.neuron_id(i)) u_neuron (
      .clk          (clk),
      .rst_n        (rst_n),
      .wport        (w_if.slave),
      .bport        (b_if.slave),
      .result_valid (nrn_valid[i]),
      .result       (results[i])
    );
  end

  rot_collector u_coll (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (&nrn_valid),  // neurons run in lockstep
    .results      (results),
    .layer        (b_if.layer),
    .argmax_go    (argmax_go),
    .hidden       (hidden),
    .layer_done   (layer_done),
    .argmax_done  (argmax_done),
    .result_idx   (result_idx)
  );

  assign angle = 8'd1 << result_idx;
  assign done  = done_pulse;

endmodule

`default_nettype wire

/* verilog/rot_pkg.sv */
`default_nettype none

package rot_pkg;

  localparam int num_inputs  = 16;
  localparam int num_neurons = 8;
  localparam int num_weights = num_inputs + num_neurons;  // both layers, per neuron
  localparam int act_shift   = 4;

  // bias slots in the weight region
  localparam int bias_idx0 = num_inputs;
  localparam int bias_idx1 = num_neurons;

  localparam logic [11:0] addr_ctrl   = 12'h000;
  localparam logic [11:0] addr_status = 12'h004;
  localparam logic [11:0] addr_result = 12'h008;
  localparam logic [11:0] addr_input  = 12'h010;
  localparam int          addr_wreg_bit = 11;

  typedef logic        [7:0]  pixel_t;
  typedef logic signed [7:0]  weight_t;
  typedef logic signed [15:0] bias_t;
  typedef logic signed [23:0] acc_t;
  typedef logic        [2:0]  nidx_t;
  typedef logic        [3:0]  widx_t;

  typedef enum logic [2:0] {
    IDLE,
    LAYER0,
    WAIT0,
    LAYER1,
    WAIT1,
    ARGMAX,
    DONE
  } seq_state_t;

endpackage

`default_nettype wire

/* verilog/rot_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module rot_sequencer import rot_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_pulse,
  input  pixel_t      pixels [num_inputs],
  input  pixel_t      hidden [num_neurons],
  rot_bcast_if.master bport,
  output logic        busy,
  input  logic        layer_done,
  input  logic        argmax_done,
  output logic        argmax_go,
  output logic        done_pulse
);

  seq_state_t state;
  widx_t      cnt;    // beat index within the layer
  logic       layer;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      cnt       <= '0;
      layer     <= 1'b0;
      argmax_go <= 1'b0;
    end else begin
      argmax_go <= 1'b0;
      case (state)
        IDLE: begin
          if (start_pulse) begin
            state <= LAYER0;
            cnt   <= '0;
            layer <= 1'b0;
          end
        end
        LAYER0: begin
          cnt <= cnt + 4'd1;
          if (cnt == widx_t'(num_inputs - 1)) begin
            state <= WAIT0;
          end
        end
        WAIT0: begin
          // hidden vector is in the collector once layer_done shows up
          if (layer_done) begin
            state <= LAYER1;
            cnt   <= '0;
            layer <= 1'b1;
          end
        end
        LAYER1: begin
          cnt <= cnt + 4'd1;
          if (cnt == widx_t'(num_neurons - 1)) begin
            state <= WAIT1;
          end
        end
        WAIT1: begin
          if (layer_done) begin
            state     <= ARGMAX;
            argmax_go <= 1'b1;  // single command
          end
        end
        ARGMAX: begin
          if (argmax_done) begin
            state <= DONE;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign bport.valid = (state == LAYER0) || (state == LAYER1);
  assign bport.first = (cnt == '0);
  assign bport.last  = layer ? (cnt == widx_t'(num_neurons - 1))
                             : (cnt == widx_t'(num_inputs - 1));
  assign bport.layer = layer;
  assign bport.widx  = cnt;
  assign bport.x     = layer ? hidden[cnt[2:0]] : pixels[cnt];

  assign busy       = (state != IDLE);
  assign done_pulse = (state == DONE);

  // scan end only while waiting for it
  a_argmax_done_in_argmax: assert property (@(posedge clk) disable iff (!rst_n)
    argmax_done |-> (state == ARGMAX));

endmodule

`default_nettype wire
